// File: common/pmp_pkg.sv
package pmp_pkg;

    // ******************************
    // Widths
    // ******************************
    localparam int xlen                = 32;
    localparam int paddr_len           = 34;
    localparam int pmp_entries_default = 16;

    typedef logic [xlen-1:0]      pmp_addr_t;   // pmpaddr holds address >> 2.
    typedef logic [paddr_len-1:0] paddr_t;
    typedef logic [7:0]           pmp_cfg_t;
    typedef logic [1:0]           pmp_mode_t;
    typedef logic [1:0]           access_t;
    typedef logic [1:0]           priv_t;

    // ******************************
    // pmpcfg byte layout
    // ******************************
    localparam int cfg_r_bit = 0;
    localparam int cfg_w_bit = 1;
    localparam int cfg_x_bit = 2;
    localparam int cfg_a_lsb = 3;   // A field is two bits wide.
    localparam int cfg_l_bit = 7;

    localparam pmp_mode_t a_off   = 2'd0;
    localparam pmp_mode_t a_tor   = 2'd1;
    localparam pmp_mode_t a_na4   = 2'd2;
    localparam pmp_mode_t a_napot = 2'd3;

    // Access type and privilege codes.
    localparam access_t acc_fetch = 2'd0;
    localparam access_t acc_load  = 2'd1;
    localparam access_t acc_store = 2'd2;

    localparam priv_t priv_u = 2'd0;
    localparam priv_t priv_s = 2'd1;
    localparam priv_t priv_m = 2'd3;

endpackage

// File: source/pmp_csr_file.sv
module pmp_csr_file #(
    parameter int  pmp_entries = pmp_pkg::pmp_entries_default,
    localparam int idx_w       = $clog2(pmp_entries)
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               cfg_we,
    input  logic [idx_w-1:0]   cfg_idx,
    input  pmp_pkg::pmp_cfg_t  cfg_wdata,
    input  logic               addr_we,
    input  logic [idx_w-1:0]   addr_idx,
    input  pmp_pkg::pmp_addr_t addr_wdata,
    output pmp_pkg::pmp_cfg_t  pmpcfg  [pmp_entries],
    output pmp_pkg::pmp_addr_t pmpaddr [pmp_entries]
);
    import pmp_pkg::*;

    pmp_cfg_t cfg_val;
    logic     cfg_ok;
    logic     addr_ok;
    logic     next_tor_lock;

    // W without R is reserved, so W is dropped.
    always_comb begin
        cfg_val = cfg_wdata;
        if (cfg_wdata[cfg_w_bit] && !cfg_wdata[cfg_r_bit]) begin
            cfg_val[cfg_w_bit] = 1'b0;
        end
    end

    // A locked TOR entry also protects the address register below it.
    always_comb begin
        next_tor_lock = 1'b0;
        for (int i = 0; i < pmp_entries - 1; i++) begin
            if (int'(addr_idx) == i) begin
                next_tor_lock = pmpcfg[i+1][cfg_l_bit] &&
                                (pmpcfg[i+1][cfg_a_lsb +: 2] == a_tor);
            end
        end
    end

    assign cfg_ok  = cfg_we && !pmpcfg[cfg_idx][cfg_l_bit];
    assign addr_ok = addr_we && !pmpcfg[addr_idx][cfg_l_bit] && !next_tor_lock;

    // ******************************
    // Entry registers
    // ******************************
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < pmp_entries; i++) begin
                pmpcfg[i] <= '0;   // All entries OFF.
            end
        end else if (cfg_ok) begin
            pmpcfg[cfg_idx] <= cfg_val;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < pmp_entries; i++) begin
                pmpaddr[i] <= '0;
            end
        end else if (addr_ok) begin
            pmpaddr[addr_idx] <= addr_wdata;
        end
    end

    // Once set, L holds the byte until reset.
    for (genvar g = 0; g < pmp_entries; g++) begin : g_lock_chk
        a_locked_cfg_stable: assert property (
            @(posedge clk) disable iff (!rstn)
            pmpcfg[g][cfg_l_bit] |=> $stable(pmpcfg[g])
        );
    end

endmodule

// File: source/pmp_region_match.sv
module pmp_region_match #(
    parameter int pmp_entries = pmp_pkg::pmp_entries_default
) (
    input  logic               clk,
    input  logic               rstn,
    input  pmp_pkg::pmp_cfg_t  pmpcfg  [pmp_entries],
    input  pmp_pkg::pmp_addr_t pmpaddr [pmp_entries],
    input  pmp_pkg::paddr_t    paddr,
    output logic               pmp_v,
    output logic               pmp_l,
    output logic               pmp_x,
    output logic               pmp_w,
    output logic               pmp_r
);
    import pmp_pkg::*;

    logic [pmp_entries-1:0] match;
    logic                   hit_l;
    logic                   hit_x;
    logic                   hit_w;
    logic                   hit_r;

    // ******************************
    // Per-entry address compare
    // ******************************
    for (genvar g = 0; g < pmp_entries; g++) begin : g_entry
        pmp_mode_t     mode;
        logic [xlen:0] ones_ext;
        logic [xlen:0] keep;
        paddr_t        mask;
        paddr_t        base;
        paddr_t        low;
        logic          napot_hit;
        logic          tor_hit;
        logic          hit;

        assign mode = pmpcfg[g][cfg_a_lsb +: 2];

        // NA4 appends a zero, so no trailing ones and a full mask.
        assign ones_ext = {pmpaddr[g], mode != a_na4};
        assign keep     = ~(ones_ext & ~(ones_ext + {{xlen{1'b0}}, 1'b1}));
        assign mask     = {keep[xlen-1:0], 2'b00};
        assign base     = {pmpaddr[g], 2'b00};

        if (g == 0) begin : g_first
            assign low = '0;
        end else begin : g_rest
            assign low = {pmpaddr[g-1], 2'b00};
        end

        assign napot_hit = ((base ^ paddr) & mask) == '0;
        assign tor_hit   = (paddr >= low) && (paddr < base);   // Top is exclusive.

        always_comb begin
            case (mode)
                a_off:   hit = 1'b0;
                a_tor:   hit = tor_hit;
                a_na4,
                a_napot: hit = napot_hit;
                default: hit = 1'b0;
            endcase
        end

        assign match[g] = hit;
    end

    // All matching entries contribute, no priority.
    always_comb begin
        hit_l = 1'b0;
        hit_x = 1'b0;
        hit_w = 1'b0;
        hit_r = 1'b0;
        for (int i = 0; i < pmp_entries; i++) begin
            hit_l = hit_l | (match[i] & pmpcfg[i][cfg_l_bit]);
            hit_x = hit_x | (match[i] & pmpcfg[i][cfg_x_bit]);
            hit_w = hit_w | (match[i] & pmpcfg[i][cfg_w_bit]);
            hit_r = hit_r | (match[i] & pmpcfg[i][cfg_r_bit]);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pmp_v <= 1'b0;
            pmp_l <= 1'b0;
            pmp_x <= 1'b0;
            pmp_w <= 1'b0;
            pmp_r <= 1'b0;
        end else begin
            pmp_v <= |match;
            pmp_l <= hit_l;
            pmp_x <= hit_x;
            pmp_w <= hit_w;
            pmp_r <= hit_r;
        end
    end

endmodule

// File: source/pmp_access_check.sv
module pmp_access_check (
    input  logic             clk,
    input  logic             rstn,
    input  logic             req_valid,
    input  pmp_pkg::access_t req_access,
    input  pmp_pkg::priv_t   req_priv,
    input  logic             pmp_v,
    input  logic             pmp_l,
    input  logic             pmp_x,
    input  logic             pmp_w,
    input  logic             pmp_r,
    output logic             resp_valid,
    output logic             resp_fault
);
    import pmp_pkg::*;

    access_t acc_q;
    priv_t   priv_q;
    logic    need;
    logic    fault;

    // Same stage as the match flags.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        acc_q  <= req_access;
        priv_q <= req_priv;
    end

    // ******************************
    // Permission decision
    // ******************************
    always_comb begin
        case (acc_q)
            acc_fetch: need = pmp_x;
            acc_load:  need = pmp_r;
            acc_store: need = pmp_w;
            default:   need = 1'b0;   // Reserved type never passes.
        endcase
    end

    always_comb begin
        if (priv_q == priv_m) begin
            fault = pmp_v && pmp_l && !need;   // M mode only checks locked entries.
        end else begin
            fault = !pmp_v || !need;
        end
    end

    assign resp_fault = resp_valid && fault;

    // An idle cycle never reports a fault one cycle later.
    a_no_fault_when_idle: assert property (
        @(posedge clk) disable iff (!rstn)
        !req_valid |=> !resp_fault
    );

endmodule

// File: source/pmp_unit.sv
module pmp_unit #(
    parameter int  pmp_entries = pmp_pkg::pmp_entries_default,
    localparam int idx_w       = $clog2(pmp_entries)
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               cfg_we,
    input  logic [idx_w-1:0]   cfg_idx,
    input  pmp_pkg::pmp_cfg_t  cfg_wdata,
    input  logic               addr_we,
    input  logic [idx_w-1:0]   addr_idx,
    input  pmp_pkg::pmp_addr_t addr_wdata,
    input  logic               req_valid,
    input  pmp_pkg::paddr_t    req_paddr,
    input  pmp_pkg::access_t   req_access,
    input  pmp_pkg::priv_t     req_priv,
    output logic               resp_valid,
    output logic               resp_fault,
    output logic               resp_l,
    output logic               resp_x,
    output logic               resp_w,
    output logic               resp_r
);
    import pmp_pkg::*;

    pmp_cfg_t  pmpcfg  [pmp_entries];
    pmp_addr_t pmpaddr [pmp_entries];
    logic      pmp_v;

    pmp_csr_file #(
        .pmp_entries (pmp_entries)
    ) u_csr_file (
        .clk        (clk),
        .rstn       (rstn),
        .cfg_we     (cfg_we),
        .cfg_idx    (cfg_idx),
        .cfg_wdata  (cfg_wdata),
        .addr_we    (addr_we),
        .addr_idx   (addr_idx),
        .addr_wdata (addr_wdata),
        .pmpcfg     (pmpcfg),
        .pmpaddr    (pmpaddr)
    );

    // Flags leave the matcher register directly as resp_*.
    pmp_region_match #(
        .pmp_entries (pmp_entries)
    ) u_region_match (
        .clk     (clk),
        .rstn    (rstn),
        .pmpcfg  (pmpcfg),
        .pmpaddr (pmpaddr),
        .paddr   (req_paddr),
        .pmp_v   (pmp_v),
        .pmp_l   (resp_l),
        .pmp_x   (resp_x),
        .pmp_w   (resp_w),
        .pmp_r   (resp_r)
    );

    pmp_access_check u_access_check (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req_access (req_access),
        .req_priv   (req_priv),
        .pmp_v      (pmp_v),
        .pmp_l      (resp_l),
        .pmp_x      (resp_x),
        .pmp_w      (resp_w),
        .pmp_r      (resp_r),
        .resp_valid (resp_valid),
        .resp_fault (resp_fault)
    );

endmodule

// File: verification/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period.
    end

    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;   // Released just after the fourth edge.
    end

endmodule

// File: verification/pmp_checker.sv
module pmp_checker #(
    parameter int  entries = 16,
    localparam int idx_w   = $clog2(entries)
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               cfg_we,
    input  logic [idx_w-1:0]   cfg_idx,
    input  pmp_pkg::pmp_cfg_t  cfg_wdata,
    input  logic               addr_we,
    input  logic [idx_w-1:0]   addr_idx,
    input  pmp_pkg::pmp_addr_t addr_wdata,
    input  logic               req_valid,
    input  pmp_pkg::paddr_t    req_paddr,
    input  pmp_pkg::access_t   req_access,
    input  pmp_pkg::priv_t     req_priv,
    input  logic               resp_valid,
    input  logic               resp_fault,
    input  logic               resp_l,
    input  logic               resp_x,
    input  logic               resp_w,
    input  logic               resp_r,
    input  logic               report,
    output int                 error_count,
    output int                 check_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import pmp_pkg::*;

    pmp_cfg_t   cfg_m  [entries];
    pmp_addr_t  addr_m [entries];
    logic [5:0] exp_q;   // {valid, fault, l, x, w, r}.
    logic       pending = 1'b0;
    int         errs    = 0;
    int         checks  = 0;

    assign error_count = errs;
    assign check_count = checks;

    // ******************************
    // Reference model
    // ******************************
    function automatic logic entry_hit(input int i, input paddr_t pa);
        logic [63:0] top;
        logic [63:0] low;
        logic [63:0] size;
        logic [63:0] pa_w;
        int          ones;
        pa_w = {30'b0, pa};
        top  = {30'b0, addr_m[i], 2'b00};
        low  = 64'd0;
        if (i > 0) begin
            low = {30'b0, addr_m[i-1], 2'b00};
        end
        ones = 0;
        while (ones < xlen && addr_m[i][ones]) begin
            ones++;
        end
        size = 64'd1 << (ones + 3);   // NAPOT region size in bytes.
        case (cfg_m[i][cfg_a_lsb +: 2])
            a_tor:   return (pa_w >= low) && (pa_w < top);
            a_na4:   return pa[paddr_len-1:2] == addr_m[i];
            a_napot: return (pa_w & ~(size - 64'd1)) == (top & ~(size - 64'd1));
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [5:0] expect_resp(input logic v, input paddr_t pa,
                                               input access_t acc, input priv_t pv);
        logic any;
        logic l;
        logic x;
        logic w;
        logic r;
        logic need;
        logic fault;
        any = 1'b0;
        l   = 1'b0;
        x   = 1'b0;
        w   = 1'b0;
        r   = 1'b0;
        for (int i = 0; i < entries; i++) begin
            if (entry_hit(i, pa)) begin
                any = 1'b1;
                l   = l | cfg_m[i][cfg_l_bit];
                x   = x | cfg_m[i][cfg_x_bit];
                w   = w | cfg_m[i][cfg_w_bit];
                r   = r | cfg_m[i][cfg_r_bit];
            end
        end
        case (acc)
            acc_load:  need = r;
            acc_store: need = w;
            acc_fetch: need = x;
            default:   need = 1'b0;
        endcase
        if (pv == priv_m) begin
            fault = any && l && !need;
        end else begin
            fault = !any || !need;
        end
        return {v, v && fault, l, x, w, r};
    endfunction

    task automatic apply_writes();
        pmp_cfg_t c;
        logic     cfg_ok;
        logic     addr_ok;
        int       nxt;
        nxt     = int'(addr_idx) + 1;
        cfg_ok  = cfg_we && !cfg_m[cfg_idx][cfg_l_bit];
        addr_ok = addr_we && !cfg_m[addr_idx][cfg_l_bit];
        if (nxt < entries) begin
            if (cfg_m[nxt][cfg_l_bit] && cfg_m[nxt][cfg_a_lsb +: 2] == a_tor) begin
                addr_ok = 1'b0;   // Base of a locked TOR range.
            end
        end
        c = cfg_wdata;
        if (c[cfg_w_bit] && !c[cfg_r_bit]) begin
            c[cfg_w_bit] = 1'b0;
        end
        if (cfg_ok) begin
            cfg_m[cfg_idx] = c;
        end
        if (addr_ok) begin
            addr_m[addr_idx] = addr_wdata;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errs++;
            $display("Fail at %0t: %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // Inputs and outputs are both settled at the falling edge.
    always @(negedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < entries; i++) begin
                cfg_m[i]  = '0;
                addr_m[i] = '0;
            end
            pending = 1'b0;
        end else begin
            if (pending) begin
                compare_bit("resp_valid", exp_q[5], resp_valid);
                compare_bit("resp_fault", exp_q[4], resp_fault);
                compare_bit("resp_l", exp_q[3], resp_l);
                compare_bit("resp_x", exp_q[2], resp_x);
                compare_bit("resp_w", exp_q[1], resp_w);
                compare_bit("resp_r", exp_q[0], resp_r);
            end
            exp_q   = expect_resp(req_valid, req_paddr, req_access, req_priv);
            pending = 1'b1;
            apply_writes();   // Lookups this cycle still see the old entries.
        end
    end

    always @(posedge report) begin
        $display("Closing: %0d errors in %0d checks", errs, checks);
    end

endmodule

// File: verification/pmp_unit_tb.sv
module pmp_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pmp_pkg::*;

    localparam int entries      = 16;
    localparam int idx_w        = $clog2(entries);
    localparam int warm_cycles  = 20;   // All entries OFF.
    localparam int mix_cycles   = 600;
    localparam int total_cycles = 4 + warm_cycles + 2 * mix_cycles + 4;
    localparam int timeout_ns   = (total_cycles + 100) * 20;

    logic             clk;
    logic             rstn;
    logic             cfg_we;
    logic [idx_w-1:0] cfg_idx;
    pmp_cfg_t         cfg_wdata;
    logic             addr_we;
    logic [idx_w-1:0] addr_idx;
    pmp_addr_t        addr_wdata;
    logic             req_valid;
    paddr_t           req_paddr;
    access_t          req_access;
    priv_t            req_priv;
    logic             resp_valid;
    logic             resp_fault;
    logic             resp_l;
    logic             resp_x;
    logic             resp_w;
    logic             resp_r;
    logic             report;
    int               error_count;
    int               check_count;
    logic [31:0]      seed = 32'h6449;
    pmp_addr_t        pool [8];   // Recent address values, reused for requests.
    logic [2:0]       pool_ptr;

    tb_clock u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    pmp_unit #(
        .pmp_entries (entries)
    ) u_dut (
        .clk        (clk),
        .rstn       (rstn),
        .cfg_we     (cfg_we),
        .cfg_idx    (cfg_idx),
        .cfg_wdata  (cfg_wdata),
        .addr_we    (addr_we),
        .addr_idx   (addr_idx),
        .addr_wdata (addr_wdata),
        .req_valid  (req_valid),
        .req_paddr  (req_paddr),
        .req_access (req_access),
        .req_priv   (req_priv),
        .resp_valid (resp_valid),
        .resp_fault (resp_fault),
        .resp_l     (resp_l),
        .resp_x     (resp_x),
        .resp_w     (resp_w),
        .resp_r     (resp_r)
    );

    pmp_checker #(
        .entries (entries)
    ) u_checker (
        .clk         (clk),
        .rstn        (rstn),
        .cfg_we      (cfg_we),
        .cfg_idx     (cfg_idx),
        .cfg_wdata   (cfg_wdata),
        .addr_we     (addr_we),
        .addr_idx    (addr_idx),
        .addr_wdata  (addr_wdata),
        .req_valid   (req_valid),
        .req_paddr   (req_paddr),
        .req_access  (req_access),
        .req_priv    (req_priv),
        .resp_valid  (resp_valid),
        .resp_fault  (resp_fault),
        .resp_l      (resp_l),
        .resp_x      (resp_x),
        .resp_w      (resp_w),
        .resp_r      (resp_r),
        .report      (report),
        .error_count (error_count),
        .check_count (check_count)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    // ******************************
    // Stimulus
    // ******************************
    // Phase 0 sends requests only, 1 adds CSR writes, 2 also sets L now and then.
    task automatic drive_cycle(input int phase);
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        @(posedge clk);
        #2;
        r = next_rand();
        a = next_rand();
        b = next_rand();
        c = next_rand();
        cfg_we    = (phase != 0) && (r[3:0] < 4'd3);
        cfg_idx   = r[4 +: idx_w];
        cfg_wdata = {(phase == 2) && (a[11:8] == 4'd0), 2'b00, a[4:0]};
        addr_we   = (phase != 0) && (r[11:8] < 4'd4);
        addr_idx  = r[12 +: idx_w];
        if (c[31:30] == 2'd0) begin
            addr_wdata = c;
        end else begin
            addr_wdata = (c & 32'h3ff) | ((32'd1 << c[14:12]) - 32'd1);   // Small NAPOT sizes.
        end
        if (addr_we) begin
            pool[pool_ptr] = addr_wdata;
            pool_ptr       = pool_ptr + 3'd1;
        end
        req_valid  = b[2:0] != 3'd0;
        req_access = (b[4:3] == 2'd3) ? acc_load : b[4:3];
        req_priv   = (b[6:5] == 2'd2) ? priv_m : b[6:5];
        case (b[9:8])
            2'd0:    req_paddr = {r[31:30], a};
            2'd3:    req_paddr = {pool[b[12:10]], 2'b00} - 34'd4 + {30'b0, b[14:13], 2'b00};
            default: req_paddr = {22'b0, a[27:16]};   // Window where most regions sit.
        endcase
    endtask

    initial begin
        cfg_we     = 1'b0;
        cfg_idx    = '0;
        cfg_wdata  = '0;
        addr_we    = 1'b0;
        addr_idx   = '0;
        addr_wdata = '0;
        req_valid  = 1'b0;
        req_paddr  = '0;
        req_access = acc_fetch;
        req_priv   = priv_m;
        report     = 1'b0;
        pool_ptr   = '0;
        for (int i = 0; i < 8; i++) begin
            pool[i] = '0;
        end
        @(posedge rstn);
        repeat (warm_cycles) drive_cycle(0);
        repeat (mix_cycles) drive_cycle(1);
        repeat (mix_cycles) drive_cycle(2);
        repeat (2) @(negedge clk);   // Last response gets compared.
        #1;
        report = 1'b1;
        #1;
        if (error_count == 0 && check_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #timeout_ns;
        $display("Timeout: the stimulus did not complete in %0d ns", timeout_ns);
        $display("test failed");
        $finish;
    end

endmodule

// File: list.f
common/pmp_pkg.sv
source/pmp_csr_file.sv
source/pmp_region_match.sv
source/pmp_access_check.sv
source/pmp_unit.sv
verification/tb_clock.sv
verification/pmp_checker.sv
verification/pmp_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= pmp_unit_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
